// File: logic/core_cfg_pkg.sv
// core configuration package
// sizes of the register file, data path and instruction queue
`default_nettype none

package core_cfg_pkg;

    // register file
    localparam int RegNum     = 32;  // architectural registers
    localparam int RegAddrBus = 5;   // register address width
    localparam int RegBus     = 32;  // data path width

    // instruction queue, depth doubles as the sender's credit count
    localparam int QueueDepth   = 4;
    localparam int QueuePtrBits = 2;

endpackage

`default_nettype wire

// File: logic/riscv_isa_pkg.sv
// RV32I instruction set definitions
// opcodes, ALU operations and instruction field positions
`default_nettype none

package riscv_isa_pkg;

    localparam int InstrBus = 32;  // instruction word width

    // field positions inside the instruction word
    localparam int OpcodeMsb = 6;
    localparam int RdLsb     = 7;
    localparam int Funct3Lsb = 12;
    localparam int Rs1Lsb    = 15;
    localparam int Rs2Lsb    = 20;
    localparam int ImmLsb    = 20;   // I-type immediate, bits 31:20
    localparam int Funct7Lsb = 25;
    localparam int AltBit    = 30;   // selects SUB / SRA

    // only the two ALU opcode groups are supported
    typedef enum logic [6:0] {
        OpcodeOp    = 7'b0110011,  // register-register
        OpcodeOpImm = 7'b0010011   // register-immediate
    } opcode_e;

    typedef enum logic [3:0] {
        AluAdd, AluSub, AluSll, AluSlt, AluSltu,
        AluXor, AluSrl, AluSra, AluOr, AluAnd
    } alu_op_e;

endpackage

`default_nettype wire

// File: logic/regs.sv
// general-purpose register file, 32 x 32
// two core read ports with write forwarding plus a debug read/write port
`timescale 1ns/1ns
`default_nettype none

module regs (
    input  wire logic                               clk_i,
    input  wire logic                               arst_n_i,
    // core write from writeback
    input  wire logic                               we_i,
    input  wire logic [core_cfg_pkg::RegAddrBus-1:0] waddr_i,
    input  wire logic [core_cfg_pkg::RegBus-1:0]     wdata_i,
    // core reads from decode
    input  wire logic [core_cfg_pkg::RegAddrBus-1:0] raddr1_i,
    output logic      [core_cfg_pkg::RegBus-1:0]     rdata1_o,
    input  wire logic [core_cfg_pkg::RegAddrBus-1:0] raddr2_i,
    output logic      [core_cfg_pkg::RegBus-1:0]     rdata2_o,
    // debug access
    input  wire logic                               dbg_we_i,
    input  wire logic [core_cfg_pkg::RegAddrBus-1:0] dbg_addr_i,
    input  wire logic [core_cfg_pkg::RegBus-1:0]     dbg_wdata_i,
    output logic      [core_cfg_pkg::RegBus-1:0]     dbg_rdata_o
);

    logic [core_cfg_pkg::RegBus-1:0] rf_q [core_cfg_pkg::RegNum];

    // core write first, debug write only when core is idle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < core_cfg_pkg::RegNum; i++) begin
                rf_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            rf_q[waddr_i] <= wdata_i;
        end else if (dbg_we_i && (dbg_addr_i != '0)) begin
            rf_q[dbg_addr_i] <= dbg_wdata_i;  // dropped if core writes too
        end
    end

    // x0 is hardwired, then forward the write in flight
    function automatic logic [core_cfg_pkg::RegBus-1:0] read_port(
        input logic [core_cfg_pkg::RegAddrBus-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (we_i && (addr == waddr_i)) begin
            return wdata_i;
        end
        return rf_q[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

    // debug view, no forwarding; x0 never gets written so it reads zero
    assign dbg_rdata_o = rf_q[dbg_addr_i];

endmodule

`default_nettype wire

// File: logic/instr_queue.sv
// instruction queue
// small circular FIFO, pops every cycle it holds an entry and
// returns one credit to the sender per pop
`timescale 1ns/1ns
`default_nettype none

module instr_queue (
    input  wire logic                              clk_i,
    input  wire logic                              arst_n_i,
    input  wire logic                              push_i,
    input  wire logic [riscv_isa_pkg::InstrBus-1:0] push_instr_i,
    output logic                                   pop_valid_o,
    output logic      [riscv_isa_pkg::InstrBus-1:0] pop_instr_o,
    output logic                                   credit_o
);

    logic [riscv_isa_pkg::InstrBus-1:0] mem_q [core_cfg_pkg::QueueDepth];
    logic [core_cfg_pkg::QueuePtrBits-1:0] wptr_q, rptr_q;
    logic [core_cfg_pkg::QueuePtrBits:0]   count_q;  // 0..QueueDepth

    // head leaves whenever something is stored
    assign pop_valid_o = (count_q != '0);
    assign pop_instr_o = mem_q[rptr_q];

    // pointers, count and credit return
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wptr_q   <= '0;
            rptr_q   <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) begin
                wptr_q <= wptr_q + 1'b1;  // wraps at depth
            end
            if (pop_valid_o) begin
                rptr_q <= rptr_q + 1'b1;
            end
            count_q  <= count_q + push_i - pop_valid_o;
            credit_o <= pop_valid_o;  // one credit per popped entry
        end
    end

    // storage, no reset needed
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wptr_q] <= push_instr_i;
        end
    end

endmodule

`default_nettype wire

// File: logic/decoder.sv
// instruction decoder for OP and OP-IMM
// splits the word into register addresses, immediate and ALU operation
// anything else is flagged illegal
`timescale 1ns/1ns
`default_nettype none

module decoder (
    input  wire logic                               valid_i,
    input  wire logic [riscv_isa_pkg::InstrBus-1:0]  instr_i,
    output logic      [core_cfg_pkg::RegAddrBus-1:0] rs1_addr_o,
    output logic      [core_cfg_pkg::RegAddrBus-1:0] rs2_addr_o,
    output logic      [core_cfg_pkg::RegAddrBus-1:0] rd_addr_o,
    output logic      [core_cfg_pkg::RegBus-1:0]     imm_o,
    output logic                                    use_imm_o,
    output riscv_isa_pkg::alu_op_e                  alu_op_o,
    output logic                                    exec_valid_o,
    output logic                                    illegal_o
);

    riscv_isa_pkg::opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;     // bit 30
    logic       legal;

    assign opcode = riscv_isa_pkg::opcode_e'(instr_i[riscv_isa_pkg::OpcodeMsb:0]);
    assign funct3 = instr_i[riscv_isa_pkg::Funct3Lsb +: 3];
    assign funct7 = instr_i[riscv_isa_pkg::Funct7Lsb +: 7];
    assign alt    = instr_i[riscv_isa_pkg::AltBit];

    assign rd_addr_o  = instr_i[riscv_isa_pkg::RdLsb +: core_cfg_pkg::RegAddrBus];
    assign rs1_addr_o = instr_i[riscv_isa_pkg::Rs1Lsb +: core_cfg_pkg::RegAddrBus];
    assign rs2_addr_o = instr_i[riscv_isa_pkg::Rs2Lsb +: core_cfg_pkg::RegAddrBus];

    // I-type immediate, sign-extended; shamt sits in the low 5 bits
    assign imm_o = {{(core_cfg_pkg::RegBus-12){instr_i[riscv_isa_pkg::InstrBus-1]}},
                    instr_i[riscv_isa_pkg::ImmLsb +: 12]};
    assign use_imm_o = (opcode == riscv_isa_pkg::OpcodeOpImm);

    always_comb begin
        legal = 1'b1;
        case (funct3)  // base op from funct3
            3'b000:  alu_op_o = riscv_isa_pkg::AluAdd;
            3'b001:  alu_op_o = riscv_isa_pkg::AluSll;
            3'b010:  alu_op_o = riscv_isa_pkg::AluSlt;
            3'b011:  alu_op_o = riscv_isa_pkg::AluSltu;
            3'b100:  alu_op_o = riscv_isa_pkg::AluXor;
            3'b101:  alu_op_o = alt ? riscv_isa_pkg::AluSra : riscv_isa_pkg::AluSrl;
            3'b110:  alu_op_o = riscv_isa_pkg::AluOr;
            default: alu_op_o = riscv_isa_pkg::AluAnd;
        endcase
        case (opcode)
            riscv_isa_pkg::OpcodeOp: begin
                if ((funct3 == 3'b000) && alt) alu_op_o = riscv_isa_pkg::AluSub;
                // funct7 is zero, or 0100000 for SUB/SRA only
                legal = (funct7 == 7'b0) ||
                        ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            riscv_isa_pkg::OpcodeOpImm: begin
                if (funct3 == 3'b001) legal = (funct7 == 7'b0);  // SLLI
                if (funct3 == 3'b101) legal = (funct7 == 7'b0) || (funct7 == 7'b0100000);
            end
            default: legal = 1'b0;  // unsupported opcode
        endcase
    end

    assign exec_valid_o = valid_i && legal;
    assign illegal_o    = valid_i && !legal;

endmodule

`default_nettype wire

// File: logic/alu_exec.sv
// execute stage
// computes the ALU result and holds it in the writeback register
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
    input  wire logic                               clk_i,
    input  wire logic                               arst_n_i,
    input  wire logic                               valid_i,
    input  wire logic                               illegal_i,
    input  wire riscv_isa_pkg::alu_op_e             alu_op_i,
    input  wire logic [core_cfg_pkg::RegBus-1:0]     rs1_data_i,
    input  wire logic [core_cfg_pkg::RegBus-1:0]     rs2_data_i,
    input  wire logic [core_cfg_pkg::RegBus-1:0]     imm_i,
    input  wire logic                               use_imm_i,
    input  wire logic [core_cfg_pkg::RegAddrBus-1:0] rd_addr_i,
    output logic                                    wb_we_o,
    output logic      [core_cfg_pkg::RegAddrBus-1:0] wb_addr_o,
    output logic      [core_cfg_pkg::RegBus-1:0]     wb_data_o,
    output logic                                    illegal_o
);

    logic [core_cfg_pkg::RegBus-1:0] op_b;
    logic [core_cfg_pkg::RegBus-1:0] result;
    logic [4:0]                      shamt;

    assign op_b  = use_imm_i ? imm_i : rs2_data_i;  // register or immediate
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_i)
            riscv_isa_pkg::AluSub:  result = rs1_data_i - op_b;
            riscv_isa_pkg::AluSll:  result = rs1_data_i << shamt;
            riscv_isa_pkg::AluSlt:  result = {{(core_cfg_pkg::RegBus-1){1'b0}},
                                              $signed(rs1_data_i) < $signed(op_b)};
            riscv_isa_pkg::AluSltu: result = {{(core_cfg_pkg::RegBus-1){1'b0}},
                                              rs1_data_i < op_b};
            riscv_isa_pkg::AluXor:  result = rs1_data_i ^ op_b;
            riscv_isa_pkg::AluSrl:  result = rs1_data_i >> shamt;
            riscv_isa_pkg::AluSra:  result = $unsigned($signed(rs1_data_i) >>> shamt);
            riscv_isa_pkg::AluOr:   result = rs1_data_i | op_b;
            riscv_isa_pkg::AluAnd:  result = rs1_data_i & op_b;
            default:                result = rs1_data_i + op_b;  // AluAdd
        endcase
    end

    // control flags, both live for one cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o   <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            wb_we_o   <= valid_i;    // rd x0 too, regs drops it
            illegal_o <= illegal_i;
        end
    end

    // writeback payload
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            wb_addr_o <= rd_addr_i;
            wb_data_o <= result;
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_core_top.sv
// integer execution slice top
// instruction queue, decode, register file and execute stage
`timescale 1ns/1ns
`default_nettype none

module alu_core_top (
    input  wire logic                               clk_i,
    input  wire logic                               arst_n_i,
    input  wire logic                               instr_valid_i,
    input  wire logic [riscv_isa_pkg::InstrBus-1:0]  instr_i,
    output logic                                    credit_o,
    output logic                                    result_valid_o,
    output logic      [core_cfg_pkg::RegAddrBus-1:0] result_rd_o,
    output logic      [core_cfg_pkg::RegBus-1:0]     result_data_o,
    output logic                                    illegal_o,
    input  wire logic                               dbg_we_i,
    input  wire logic [core_cfg_pkg::RegAddrBus-1:0] dbg_addr_i,
    input  wire logic [core_cfg_pkg::RegBus-1:0]     dbg_wdata_i,
    output logic      [core_cfg_pkg::RegBus-1:0]     dbg_rdata_o
);

    logic                               pop_valid;
    logic [riscv_isa_pkg::InstrBus-1:0]  pop_instr;
    logic [core_cfg_pkg::RegAddrBus-1:0] rs1_addr, rs2_addr, rd_addr;
    logic [core_cfg_pkg::RegBus-1:0]     rs1_data, rs2_data, imm;
    logic                               use_imm, exec_valid, illegal;
    riscv_isa_pkg::alu_op_e             alu_op;

    instr_queue u_queue (
        .clk_i, .arst_n_i,
        .push_i      (instr_valid_i),
        .push_instr_i(instr_i),
        .pop_valid_o (pop_valid),
        .pop_instr_o (pop_instr),
        .credit_o
    );

    decoder u_decoder (
        .valid_i(pop_valid), .instr_i(pop_instr),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
        .imm_o(imm), .use_imm_o(use_imm), .alu_op_o(alu_op),
        .exec_valid_o(exec_valid), .illegal_o(illegal)
    );

    // writeback register doubles as the result port
    regs u_regs (
        .clk_i, .arst_n_i,
        .we_i(result_valid_o), .waddr_i(result_rd_o), .wdata_i(result_data_o),
        .raddr1_i(rs1_addr), .rdata1_o(rs1_data),
        .raddr2_i(rs2_addr), .rdata2_o(rs2_data),
        .dbg_we_i, .dbg_addr_i, .dbg_wdata_i, .dbg_rdata_o
    );

    alu_exec u_exec (
        .clk_i, .arst_n_i,
        .valid_i(exec_valid), .illegal_i(illegal), .alu_op_i(alu_op),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .imm_i(imm), .use_imm_i(use_imm), .rd_addr_i(rd_addr),
        .wb_we_o(result_valid_o), .wb_addr_o(result_rd_o), .wb_data_o(result_data_o),
        .illegal_o
    );

endmodule

`default_nettype wire

// File: verification/alu_core_assert.sv
// concurrent checks on the execution slice, bound into the top level
// credit rule, result vs illegal exclusion, credit state after reset
`timescale 1ns/1ns
`default_nettype none

module alu_core_assert (
    input wire logic clk_i,
    input wire logic arst_n_i,
    input wire logic instr_valid_i,
    input wire logic credit_i,
    input wire logic result_valid_i,
    input wire logic illegal_i
);

    int credits;     // sender credits as seen from the dut side
    int fail_count;  // read by the testbench summary

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credits <= core_cfg_pkg::QueueDepth;
        end else begin
            credits <= credits - int'(instr_valid_i) + int'(credit_i);
        end
    end

    initial fail_count = 0;

    // a credit coming back in this cycle may be spent right away
    push_has_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_valid_i |-> (credits + int'(credit_i)) > 0)
        else begin
            $error("push made with no credit left");
            fail_count++;
        end

    result_not_illegal: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(result_valid_i && illegal_i))
        else begin
            $error("result beat together with illegal flag");
            fail_count++;
        end

    credit_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !credit_i)
        else begin
            $error("credit pulse right after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: verification/alu_core_checker.sv
// result checker for the execution slice
// compares result beats, illegal pulses and debug reads with expected values
`timescale 1ns/1ns
`default_nettype none

module alu_core_checker (
    input wire logic                                clk_i,
    input wire logic                                arst_n_i,
    input wire logic                                result_valid_i,
    input wire logic [core_cfg_pkg::RegAddrBus-1:0] result_rd_i,
    input wire logic [core_cfg_pkg::RegBus-1:0]     result_data_i,
    input wire logic                                illegal_i,
    input wire logic [core_cfg_pkg::RegBus-1:0]     dbg_rdata_i
);

    logic [core_cfg_pkg::RegAddrBus+core_cfg_pkg::RegBus-1:0] exp_q [$];  // {rd, value}
    int err_count = 0;
    int test_count = 0;
    int illegal_pending = 0;

    task automatic expect_result(input logic [4:0] rd, input logic [31:0] value);
        exp_q.push_back({rd, value});
    endtask

    task automatic expect_illegal();
        illegal_pending++;
    endtask

    function automatic int pending();
        return exp_q.size() + illegal_pending;
    endfunction

    // called half a cycle or more after the address was driven
    task automatic check_debug(input logic [4:0] addr, input logic [31:0] value);
        test_count++;
        if (dbg_rdata_i !== value) begin
            err_count++;
            $display("Mismatch at %0t: dbg_rdata_o (x%0d) expected %h got %h",
                     $time, addr, value, dbg_rdata_i);
        end else $display("test %0d: debug read x%0d = %h ok", test_count, addr, value);
    endtask

    // outputs move on the rising edge, look at them mid cycle
    always @(negedge clk_i) begin
        logic [36:0] exp;
        bit          beat_ok;
        if (arst_n_i && result_valid_i) begin
            test_count++;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("result beat at %0t with nothing expected", $time);
            end else begin
                exp     = exp_q.pop_front();
                beat_ok = 1'b1;
                if (result_rd_i !== exp[36:32]) begin
                    beat_ok = 1'b0;
                    $display("Mismatch at %0t: result_rd_o expected x%0d got x%0d",
                             $time, exp[36:32], result_rd_i);
                end
                if (result_data_i !== exp[31:0]) begin
                    beat_ok = 1'b0;
                    $display("Mismatch at %0t: result_data_o expected %h got %h",
                             $time, exp[31:0], result_data_i);
                end
                if (beat_ok) begin
                    $display("test %0d: x%0d = %h ok", test_count, result_rd_i, result_data_i);
                end else begin
                    err_count++;
                end
            end
        end
        if (arst_n_i && illegal_i) begin
            test_count++;
            if (illegal_pending == 0) begin
                err_count++;
                $display("illegal pulse at %0t that was not expected", $time);
            end else begin
                illegal_pending--;
                $display("test %0d: illegal instruction flagged ok", test_count);
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/alu_core_tb.sv
// testbench for the integer execution slice
// reads the trace, drives instructions under credit control and debug accesses
`timescale 1ns/1ns
`default_nettype none

module alu_core_tb;

    localparam int ClkPeriod = 40;

    logic        clk, arst_n, instr_valid, dbg_we;
    logic [31:0] instr, dbg_wdata;
    logic [4:0]  dbg_addr;
    wire logic        credit, result_valid, illegal;
    wire logic [4:0]  result_rd;
    wire logic [31:0] result_data, dbg_rdata;

    int credits, credit_pulses, pushes, tb_errors, n_steps;
    bit loaded;
    logic [7:0]  step_kind [64];
    logic [31:0] step_a [64], step_b [64], step_c [64];

    alu_core_top dut (
        .clk_i(clk), .arst_n_i(arst_n), .instr_valid_i(instr_valid), .instr_i(instr),
        .credit_o(credit), .result_valid_o(result_valid), .result_rd_o(result_rd),
        .result_data_o(result_data), .illegal_o(illegal), .dbg_we_i(dbg_we),
        .dbg_addr_i(dbg_addr), .dbg_wdata_i(dbg_wdata), .dbg_rdata_o(dbg_rdata)
    );

    alu_core_checker chk (
        .clk_i(clk), .arst_n_i(arst_n), .result_valid_i(result_valid),
        .result_rd_i(result_rd), .result_data_i(result_data), .illegal_i(illegal),
        .dbg_rdata_i(dbg_rdata)
    );

    bind alu_core_top alu_core_assert u_assert (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .instr_valid_i(instr_valid_i),
        .credit_i(credit_o), .result_valid_i(result_valid_o), .illegal_i(illegal_o)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // credits come back mid cycle
    always @(negedge clk) if (arst_n && credit) begin
        credits++;
        credit_pulses++;
    end

    task automatic load_trace();
        int fd;
        int got;
        string line;
        logic [7:0] k;
        logic [31:0] a, b, c;
        fd = $fopen("verification/alu_core_trace.txt", "r");
        if (fd == 0) return;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) continue;
            got = $sscanf(line, "%c %h %h %h", k, a, b, c);
            if (got == 4 && k != "#") begin  // skip comments and blank lines
                step_kind[n_steps] = k;
                step_a[n_steps] = a;
                step_b[n_steps] = b;
                step_c[n_steps] = c;
                n_steps++;
            end
        end
        $fclose(fd);
    endtask

    task automatic push_instr(input logic [31:0] word, input bit use_gap);
        while (credits == 0) @(negedge clk);  // hold off until a credit is back
        instr_valid = 1'b1;
        instr = word;
        credits--;
        pushes++;
        @(negedge clk);
        instr_valid = 1'b0;
        if (use_gap) repeat ($urandom_range(2, 0)) @(negedge clk);
    endtask

    // queue empty, results seen, last writeback landed
    task automatic drain();
        while (credits != core_cfg_pkg::QueueDepth || chk.pending() != 0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic debug_write(input logic [4:0] addr, input logic [31:0] data);
        dbg_we = 1'b1;
        dbg_addr = addr;
        dbg_wdata = data;
        @(negedge clk);
        dbg_we = 1'b0;
    endtask

    initial begin
        int total;
        void'($urandom(32'h6662));
        {instr_valid, dbg_we, instr, dbg_wdata, dbg_addr} = '0;
        arst_n = 1'b0;
        credits = core_cfg_pkg::QueueDepth;
        load_trace();
        loaded = 1'b1;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        if (n_steps == 0) begin
            tb_errors++;
            $display("trace file missing or empty");
        end
        for (int i = 0; i < n_steps; i++) begin
            case (step_kind[i])
                "I": begin
                    chk.expect_result(step_b[i][4:0], step_c[i]);
                    push_instr(step_a[i], 1'b1);
                end
                "X": begin
                    chk.expect_illegal();
                    push_instr(step_a[i], 1'b1);
                end
                "W": begin
                    drain();
                    debug_write(step_a[i][4:0], step_b[i]);
                end
                "R": begin
                    drain();
                    dbg_addr = step_a[i][4:0];
                    @(negedge clk);
                    chk.check_debug(step_a[i][4:0], step_c[i]);
                end
                "C": begin  // debug write lands in the writeback cycle
                    drain();
                    chk.expect_result(step_b[i][4:0], step_c[i]);
                    push_instr(step_a[i], 1'b0);
                    while (!result_valid) @(negedge clk);  // core write at next edge
                    debug_write(step_b[i][4:0], 32'hdeadbeef);
                end
                default: begin
                    tb_errors++;
                    $display("unknown step kind in trace line %0d", i);
                end
            endcase
        end
        drain();
        if (credit_pulses != pushes) begin
            tb_errors++;
            $display("credit pulses %0d do not match %0d pushes", credit_pulses, pushes);
        end
        total = chk.err_count + tb_errors + dut.u_assert.fail_count;
        $display("tests %0d, pushes %0d, credits %0d, errors %0d",
                 chk.test_count, pushes, credit_pulses, total);
        if (total == 0) $display("NO ERRORS");
        else $display("ERRORS FOUND");
        $finish;
    end

    // run length scales with the trace
    initial begin
        wait (loaded);
        #(ClkPeriod * (n_steps * 10 + 100));
        $display("timeout, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/alu_core_trace.txt
# kind a b c: I/C instr rd value, X instr 0 0, W addr data 0, R addr 0 value
# C also drives a debug write of deadbeef to rd while the core writes it
W 01 fffffff6 0
W 02 00000003 0
R 01 0 fffffff6
I 002081b3 03 fffffff9
I 40208233 04 fffffff3
I 002092b3 05 ffffffb0
I 0020a333 06 00000001
I 0020b3b3 07 00000000
I 0020c433 08 fffffff5
I 0020d4b3 09 1ffffffe
I 4020d533 0a fffffffe
I 0020e5b3 0b fffffff7
I 0020f633 0c 00000002
I 00508693 0d fffffffb
I 00409713 0e ffffff60
I fff0a793 0f 00000001
I fff0b813 10 00000001
I 0ff0c893 11 ffffff09
I 0040d913 12 0fffffff
I 4010d993 13 fffffffb
I 01016a13 14 00000013
I 07f0fa93 15 00000076
I 00100b13 16 00000001
I 016b0b33 16 00000002
I 016b0b33 16 00000004
I 002b1b13 16 00000010
I 00708013 00 fffffffd
I 00200bb3 17 00000003
R 00 0 00000000
C 05500c13 18 00000055
R 18 0 00000055
X 00002083 0 0
I 00100b13 16 00000001
W 19 12345678 0
R 19 0 12345678

// File: list.f
logic/core_cfg_pkg.sv
logic/riscv_isa_pkg.sv
logic/regs.sv
logic/instr_queue.sv
logic/decoder.sv
logic/alu_exec.sv
logic/alu_core_top.sv
verification/alu_core_assert.sv
verification/alu_core_checker.sv
verification/alu_core_tb.sv

// File: Bender.yml
package:
  name: alu_core

sources:
  - logic/core_cfg_pkg.sv
  - logic/riscv_isa_pkg.sv
  - logic/regs.sv
  - logic/instr_queue.sv
  - logic/decoder.sv
  - logic/alu_exec.sv
  - logic/alu_core_top.sv
  - target: simulation
    files:
      - verification/alu_core_assert.sv
      - verification/alu_core_checker.sv
      - verification/alu_core_tb.sv
